//--- hdl/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// Global history length in bits
`define BP_HIST_BITS 4

// PC bits that pick one pattern table
`define BP_SEL_BITS 3

`define BP_PC_WIDTH 16

// Table select starts above the low fetch bits
`define BP_SEL_LSB 4

// Derived table geometry
`define BP_NUM_TABLES (1 << `BP_SEL_BITS)
`define BP_TABLE_DEPTH (1 << `BP_HIST_BITS)

`endif

//--- hdl/bp_pkg.sv
`include "bp_params.svh"

package bp_pkg;

    typedef logic [`BP_PC_WIDTH-1:0]  pc_t;
    typedef logic [`BP_HIST_BITS-1:0] hist_t;
    typedef logic [`BP_SEL_BITS-1:0]  table_sel_t;
    typedef logic [1:0]               ctr_t;

    // Two-bit counter encodings
    localparam ctr_t CTR_SNT = 2'b00; // strongly not taken
    localparam ctr_t CTR_WNT = 2'b01; // weakly not taken at reset
    localparam ctr_t CTR_ST  = 2'b11; // strongly taken

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } pred_req_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
    } resolve_t;

    // Resolved outcome reduced to a table number
    typedef struct packed {
        logic       valid;
        table_sel_t sel;
        logic       taken;
    } update_t;

    typedef struct packed {
        logic valid;
        logic taken;
        ctr_t ctr; // confidence for the core
    } prediction_t;

endpackage

//--- hdl/resolve_capture.sv
`include "bp_params.svh"

module resolve_capture
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  resolve_t resolve,
    output update_t  upd
);

    logic       upd_valid_q;
    table_sel_t upd_sel_q;
    logic       upd_taken_q;
    table_sel_t resolve_sel;

    // Table number of the resolving branch
    assign resolve_sel = resolve.pc[`BP_SEL_LSB +: `BP_SEL_BITS];

    // Pending update flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_valid_q <= 1'b0;
        end else if (!stall) begin
            upd_valid_q <= resolve.valid;
        end
        // Pending update kept until the stall ends
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            upd_sel_q   <= resolve_sel;
            upd_taken_q <= resolve.taken;
        end
    end

    assign upd.valid = upd_valid_q;
    assign upd.sel   = upd_sel_q;
    assign upd.taken = upd_taken_q;

endmodule

//--- hdl/global_history.sv
`include "bp_params.svh"

module global_history
    import bp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  update_t upd,
    output hist_t   hist
);

    hist_t hist_q;
    hist_t hist_next;

    // Newest outcome enters at bit 0, oldest falls off the top
    assign hist_next = {hist_q[`BP_HIST_BITS-2:0], upd.taken};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_q <= '0;
        end else if (!stall && upd.valid) begin
            hist_q <= hist_next;
        end
    end

    // One history for every table
    assign hist = hist_q;

endmodule

//--- hdl/pattern_table_bank.sv
`include "bp_params.svh"

module pattern_table_bank
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  table_sel_t rd_sel,
    input  hist_t      hist,
    input  update_t    upd,
    output ctr_t       rd_ctr
);

    localparam int NUM_TABLES  = `BP_NUM_TABLES;
    localparam int TABLE_DEPTH = `BP_TABLE_DEPTH;

    ctr_t ctr_mem [NUM_TABLES][TABLE_DEPTH];

    ctr_t wr_cur;
    ctr_t wr_next;

    // Lookup for the fetch side
    assign rd_ctr = ctr_mem[rd_sel][hist];

    // Write side uses the history as it stands before this update shifts it
    assign wr_cur = ctr_mem[upd.sel][hist];

    always_comb begin
        wr_next = wr_cur;
        if (upd.taken) begin
            if (wr_cur != CTR_ST) begin
                wr_next = wr_cur + 2'd1;
            end
        end else begin
            if (wr_cur != CTR_SNT) begin
                wr_next = wr_cur - 2'd1;
            end
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_TABLES; t++) begin
                for (int e = 0; e < TABLE_DEPTH; e++) begin
                    ctr_mem[t][e] <= CTR_WNT;
                end
            end
        end else if (!stall && upd.valid) begin
            ctr_mem[upd.sel][hist] <= wr_next;
        end
    end

endmodule

//--- hdl/prediction_stage.sv
module prediction_stage
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        req_valid,
    input  ctr_t        rd_ctr,
    output prediction_t prediction
);

    logic pred_valid_q;
    logic pred_taken_q;
    ctr_t pred_ctr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid_q <= 1'b0;
        end else if (!stall) begin
            pred_valid_q <= req_valid; // drops when no request
        end
    end

    // Held under stall so the core keeps its last answer
    always_ff @(posedge clk) begin
        if (!stall) begin
            pred_ctr_q   <= rd_ctr;
            pred_taken_q <= rd_ctr[1]; // upper counter bit
        end
    end

    assign prediction.valid = pred_valid_q;
    assign prediction.taken = pred_taken_q;
    assign prediction.ctr   = pred_ctr_q;

endmodule

//--- hdl/branch_predictor.sv
`include "bp_params.svh"

module branch_predictor
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  pred_req_t   pred_req,
    input  resolve_t    resolve,
    output prediction_t prediction
);

    update_t    upd;
    hist_t      hist;
    table_sel_t rd_sel;
    ctr_t       rd_ctr;

    // Table for the fetch PC
    assign rd_sel = pred_req.pc[`BP_SEL_LSB +: `BP_SEL_BITS];

    resolve_capture u_resolve_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .resolve (resolve),
        .upd     (upd)
    );

    global_history u_global_history (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .upd   (upd),
        .hist  (hist)
    );

    // Same history drives read and write in a cycle
    pattern_table_bank u_pattern_table_bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .rd_sel (rd_sel),
        .hist   (hist),
        .upd    (upd),
        .rd_ctr (rd_ctr)
    );

    prediction_stage u_prediction_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .req_valid  (pred_req.valid),
        .rd_ctr     (rd_ctr),
        .prediction (prediction)
    );

endmodule

//--- tests/tb_branch_predictor.sv
module tb_branch_predictor
    import bp_pkg::*;
();

    localparam string       DATA_FILE = "tests/branch_predictor_testdata.txt";
    localparam logic [31:0] LFSR_SEED = 32'hee58;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int          IDLE_GAP  = 3;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    pred_req_t   pred_req;
    resolve_t    resolve;
    prediction_t prediction;

    // Operations as read from the data file
    int    op_q[$];
    pc_t   pc_q[$];
    logic  taken_q[$];
    logic  exp_taken_q[$];
    ctr_t  exp_ctr_q[$];
    int    group_q[$];
    string group_names[$];

    logic [31:0] lfsr_state;
    logic        ops_loaded = 1'b0;
    int          err_count;
    int          check_count;
    int          group_errs;
    int          groups_passed;
    int          groups_failed;

    branch_predictor u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .pred_req   (pred_req),
        .resolve    (resolve),
        .prediction (prediction)
    );

    always #5 clk = ~clk;

    // Worst case per line is a 3 cycle stall, the accept edge and the idle gap
    initial begin
        longint limit;
        wait (ops_loaded);
        limit = longint'(op_q.size()) * 8 * 10 + 1000;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display(">>> FAIL");
        $finish;
    end

    // Galois LFSR stepped once per output bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    task automatic count_error();
        err_count++;
        group_errs++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic load_ops();
        int    fd;
        int    n;
        string line;
        string name;
        int    op;
        pc_t   pc;
        logic  tk;
        logic  etk;
        ctr_t  ectr;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", DATA_FILE);
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    if (line.getc(0) == "@") begin
                        if ($sscanf(line, "@ %s", name) == 1) begin
                            group_names.push_back(name);
                        end
                    end else if ($sscanf(line, "%d %h %b %b %b", op, pc, tk, etk, ectr) == 5) begin
                        if (group_names.size() == 0) begin
                            group_names.push_back("ungrouped");
                        end
                        op_q.push_back(op);
                        pc_q.push_back(pc);
                        taken_q.push_back(tk);
                        exp_taken_q.push_back(etk);
                        exp_ctr_q.push_back(ectr);
                        group_q.push_back(group_names.size() - 1);
                    end else begin
                        $display("Malformed line in the stimulus file: %s", line);
                        err_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_predict(input pc_t pc, input logic exp_taken, input ctr_t exp_ctr);
        pred_req.valid = 1'b1;
        pred_req.pc    = pc;
        @(posedge clk);
        #1;
        pred_req = '0;
        check_count += 3;
        if (prediction.valid !== 1'b1) begin
            $display("ERR t=%0t prediction.valid got %b expected 1", $time, prediction.valid);
            count_error();
        end
        if (prediction.taken !== exp_taken) begin
            $display("ERR t=%0t prediction.taken got %b expected %b", $time,
                     prediction.taken, exp_taken);
            count_error();
        end
        if (prediction.ctr !== exp_ctr) begin
            $display("ERR t=%0t prediction.ctr got %b expected %b", $time,
                     prediction.ctr, exp_ctr);
            count_error();
        end
        @(posedge clk);
        #1;
        check_count++;
        if (prediction.valid !== 1'b0) begin // no request this cycle
            $display("ERR t=%0t prediction.valid got %b expected 0", $time, prediction.valid);
            count_error();
        end
        idle_cycles(IDLE_GAP - 1);
    endtask

    task automatic run_resolve(input pc_t pc, input logic taken);
        logic [1:0]  stall_len;
        prediction_t held;
        stall_len[1]  = next_random_bit();
        stall_len[0]  = next_random_bit();
        resolve.valid = 1'b1;
        resolve.pc    = pc;
        resolve.taken = taken;
        if (stall_len != 2'd0) begin
            stall          = 1'b1;
            pred_req.valid = 1'b1; // must be ignored
            pred_req.pc    = pc ^ 16'h0010;
        end
        held = prediction;
        repeat (stall_len) begin
            @(posedge clk);
            #1;
            check_count++;
            if (prediction !== held) begin
                $display("ERR t=%0t prediction got %h expected %h", $time, prediction, held);
                count_error();
            end
        end
        stall    = 1'b0;
        pred_req = '0;
        @(posedge clk); // Accept edge
        #1;
        resolve = '0;
        idle_cycles(IDLE_GAP);
    endtask

    task automatic report_group(input int idx);
        if (group_errs == 0) begin
            groups_passed++;
            $display("Test %s: ok", group_names[idx]);
        end else begin
            groups_failed++;
            $display("Test %s: %0d errors", group_names[idx], group_errs);
        end
    endtask

    initial begin
        int cur_group;
        rst_n         = 1'b0;
        stall         = 1'b0;
        pred_req      = '0;
        resolve       = '0;
        lfsr_state    = LFSR_SEED;
        err_count     = 0;
        check_count   = 0;
        group_errs    = 0;
        groups_passed = 0;
        groups_failed = 0;
        load_ops();
        ops_loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cur_group = -1;
        for (int i = 0; i < op_q.size(); i++) begin
            if (group_q[i] != cur_group) begin
                if (cur_group >= 0) begin
                    report_group(cur_group);
                end
                cur_group  = group_q[i];
                group_errs = 0;
            end
            if (op_q[i] == 0) begin
                run_predict(pc_q[i], exp_taken_q[i], exp_ctr_q[i]);
            end else begin
                run_resolve(pc_q[i], taken_q[i]);
            end
        end
        if (cur_group >= 0) begin
            report_group(cur_group);
        end
        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 groups_passed, groups_failed, check_count, err_count);
        if (err_count == 0 && op_q.size() > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tests/branch_predictor_testdata.txt
# op pc taken exp_taken exp_ctr
# op 0 predicts, op 1 resolves; expected columns count only for predicts
@ reset_state
0 0000 0 0 01
0 1234 0 0 01
0 fff0 0 0 01
@ saturation
1 0020 1 0 00
1 0020 1 0 00
1 0020 1 0 00
1 0020 1 0 00
0 0020 0 0 01
1 0020 1 0 00
0 0020 0 1 10
1 0020 1 0 00
0 0020 0 1 11
1 0020 1 0 00
0 0020 0 1 11
1 0020 0 0 00
1 0020 0 0 00
1 0020 0 0 00
1 0020 0 0 00
0 0020 0 1 10
1 0020 0 0 00
0 0020 0 0 01
1 0020 0 0 00
0 0020 0 0 00
1 0020 0 0 00
0 0020 0 0 00
@ history_index
1 0050 1 0 00
0 0050 0 0 01
1 0050 0 0 00
0 0050 0 0 01
1 0050 1 0 00
0 0050 0 0 01
1 0050 0 0 00
0 0050 0 0 01
1 0050 1 0 00
0 0050 0 0 00
1 0050 0 0 00
0 0050 0 1 10
@ table_select
1 0070 1 0 00
1 0070 1 0 00
1 0070 1 0 00
1 0070 1 0 00
1 0030 1 0 00
0 0030 0 1 10
0 0040 0 0 01
0 8b3c 0 1 10
1 0040 1 0 00
1 0040 1 0 00
0 0040 0 1 11
0 0030 0 1 10
0 7035 0 1 10
@ stall
1 0070 1 0 00
0 0070 0 1 10
1 0060 1 0 00
0 0060 0 1 10
0 0070 0 1 10

//--- branch_predictor.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/resolve_capture.sv
hdl/global_history.sv
hdl/pattern_table_bank.sv
hdl/prediction_stage.sv
hdl/branch_predictor.sv
tests/tb_branch_predictor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f branch_predictor.f \
    --top-module tb_branch_predictor \
    -o sim_branch_predictor

./obj_dir/sim_branch_predictor > sim.log 2>&1
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
